//--- common/rv_pkg.sv
package rv_pkg;

  typedef logic [31:0] word_t;
  typedef logic [31:0] addr_t;
  typedef logic [31:0] inst_t;
  typedef logic [4:0]  reg_addr_t;

  localparam int unsigned NUM_REGS   = 32;
  localparam int unsigned INST_BYTES = 4;   // PC step.
  localparam reg_addr_t   ZERO_REG   = 5'd0;

  // ##############################
  // Opcodes
  // ##############################
  localparam logic [6:0] OPCODE_OP     = 7'b011_0011;
  localparam logic [6:0] OPCODE_OP_IMM = 7'b001_0011;
  localparam logic [6:0] OPCODE_LOAD   = 7'b000_0011;
  localparam logic [6:0] OPCODE_STORE  = 7'b010_0011;
  localparam logic [6:0] OPCODE_BRANCH = 7'b110_0011;
  localparam logic [6:0] OPCODE_JAL    = 7'b110_1111;
  localparam logic [6:0] OPCODE_JALR   = 7'b110_0111;
  localparam logic [6:0] OPCODE_LUI    = 7'b011_0111;
  localparam logic [6:0] OPCODE_AUIPC  = 7'b001_0111;
  localparam logic [6:0] OPCODE_SYSTEM = 7'b111_0011;

  // ##############################
  // Function fields
  // ##############################
  localparam logic [2:0] FUNCT3_ADD  = 3'b000;   // Also SUB.
  localparam logic [2:0] FUNCT3_SLL  = 3'b001;
  localparam logic [2:0] FUNCT3_SLT  = 3'b010;
  localparam logic [2:0] FUNCT3_SLTU = 3'b011;
  localparam logic [2:0] FUNCT3_XOR  = 3'b100;
  localparam logic [2:0] FUNCT3_SR   = 3'b101;   // SRL and SRA.
  localparam logic [2:0] FUNCT3_OR   = 3'b110;
  localparam logic [2:0] FUNCT3_AND  = 3'b111;

  localparam logic [2:0] FUNCT3_BEQ  = 3'b000;
  localparam logic [2:0] FUNCT3_BNE  = 3'b001;
  localparam logic [2:0] FUNCT3_BLT  = 3'b100;
  localparam logic [2:0] FUNCT3_BGE  = 3'b101;
  localparam logic [2:0] FUNCT3_BLTU = 3'b110;
  localparam logic [2:0] FUNCT3_BGEU = 3'b111;

  localparam logic [2:0] FUNCT3_LB   = 3'b000;
  localparam logic [2:0] FUNCT3_LH   = 3'b001;
  localparam logic [2:0] FUNCT3_LW   = 3'b010;
  localparam logic [2:0] FUNCT3_LBU  = 3'b100;
  localparam logic [2:0] FUNCT3_LHU  = 3'b101;
  localparam logic [2:0] FUNCT3_SB   = 3'b000;
  localparam logic [2:0] FUNCT3_SH   = 3'b001;
  localparam logic [2:0] FUNCT3_SW   = 3'b010;

  localparam logic [2:0] FUNCT3_JALR  = 3'b000;
  localparam logic [2:0] FUNCT3_PRIV  = 3'b000;
  localparam logic [2:0] FUNCT3_CSRRW = 3'b001;
  localparam logic [2:0] FUNCT3_CSRRS = 3'b010;

  localparam logic [6:0] FUNCT7_BASE   = 7'h00;
  localparam logic [6:0] FUNCT7_ALT    = 7'h20;   // SUB and SRA.
  localparam logic [6:0] FUNCT7_MULDIV = 7'h01;

  localparam logic [11:0] FUNCT12_ECALL  = 12'h000;
  localparam logic [11:0] FUNCT12_EBREAK = 12'h001;
  localparam logic [11:0] FUNCT12_MRET   = 12'h302;

  typedef enum logic [3:0] {
    INST_NOP, INST_RR, INST_RI, INST_LOAD, INST_STORE, INST_BRANCH,
    INST_JAL, INST_JALR, INST_LUI, INST_AUIPC, INST_SYSTEM
  } inst_class_e;

  typedef enum logic [3:0] {
    ALU_OP_NOP, ALU_OP_ADD, ALU_OP_SUB, ALU_OP_XOR, ALU_OP_OR, ALU_OP_AND,
    ALU_OP_SLL, ALU_OP_SRL, ALU_OP_SRA, ALU_OP_SLT, ALU_OP_SLTU, ALU_OP_JUMP
  } alu_op_e;

  typedef enum logic [3:0] {
    BPU_OP_NOP, BPU_OP_BEQ, BPU_OP_BNE, BPU_OP_BLT, BPU_OP_BGE,
    BPU_OP_BLTU, BPU_OP_BGEU, BPU_OP_JAL, BPU_OP_JALR
  } bpu_op_e;

  typedef enum logic [3:0] {
    LSU_OP_NOP, LSU_OP_LB, LSU_OP_LH, LSU_OP_LW, LSU_OP_LBU, LSU_OP_LHU,
    LSU_OP_SB, LSU_OP_SH, LSU_OP_SW
  } lsu_op_e;

endpackage

//--- decode/rv_decode.sv
`timescale 1ns/10ps

module rv_decode import rv_pkg::*; (
  input  addr_t       pc_i,
  input  inst_t       inst_i,
  output inst_class_e inst_class_o,
  output alu_op_e     alu_op_o,
  output bpu_op_e     bpu_op_o,
  output logic        alu_src_imm_o,
  output logic        wena_o,
  output reg_addr_t   waddr_o,
  output word_t       imm_o,
  output reg_addr_t   raddr1_o,
  output reg_addr_t   raddr2_o,
  output logic        unsupported_o
);

  // ##############################
  // Fields and immediates
  // ##############################
  wire [11:0]     funct12 = inst_i[31:20];
  wire [6:0]      funct7  = inst_i[31:25];
  wire reg_addr_t rs2     = inst_i[24:20];
  wire reg_addr_t rs1     = inst_i[19:15];
  wire [2:0]      funct3  = inst_i[14:12];
  wire reg_addr_t rd      = inst_i[11:7];
  wire [6:0]      opcode  = inst_i[6:0];

  wire word_t imm_i  = {{21{inst_i[31]}}, inst_i[30:20]};
  wire word_t imm_s  = {{21{inst_i[31]}}, inst_i[30:25], inst_i[11:7]};
  wire word_t imm_b  = {{20{inst_i[31]}}, inst_i[7], inst_i[30:25], inst_i[11:8], 1'b0};
  wire word_t imm_u  = {inst_i[31:12], 12'b0};
  wire word_t imm_j  = {{12{inst_i[31]}}, inst_i[19:12], inst_i[20], inst_i[30:21], 1'b0};
  wire word_t imm_sh = {27'b0, inst_i[24:20]};

  // ##############################
  // Instruction match terms
  // ##############################
  wire is_op   = (opcode == OPCODE_OP);
  wire is_opi  = (opcode == OPCODE_OP_IMM);
  wire is_br   = (opcode == OPCODE_BRANCH);
  wire is_sys  = (opcode == OPCODE_SYSTEM);
  wire f7_base = (funct7 == FUNCT7_BASE);
  wire f7_alt  = (funct7 == FUNCT7_ALT);

  wire inst_add   = is_op & (funct3 == FUNCT3_ADD)  & f7_base;
  wire inst_sub   = is_op & (funct3 == FUNCT3_ADD)  & f7_alt;
  wire inst_sll   = is_op & (funct3 == FUNCT3_SLL)  & f7_base;
  wire inst_slt   = is_op & (funct3 == FUNCT3_SLT)  & f7_base;
  wire inst_sltu  = is_op & (funct3 == FUNCT3_SLTU) & f7_base;
  wire inst_xor   = is_op & (funct3 == FUNCT3_XOR)  & f7_base;
  wire inst_srl   = is_op & (funct3 == FUNCT3_SR)   & f7_base;
  wire inst_sra   = is_op & (funct3 == FUNCT3_SR)   & f7_alt;
  wire inst_or    = is_op & (funct3 == FUNCT3_OR)   & f7_base;
  wire inst_and   = is_op & (funct3 == FUNCT3_AND)  & f7_base;
  wire inst_muldv = is_op & (funct7 == FUNCT7_MULDIV);

  wire inst_addi  = is_opi & (funct3 == FUNCT3_ADD);
  wire inst_slti  = is_opi & (funct3 == FUNCT3_SLT);
  wire inst_sltiu = is_opi & (funct3 == FUNCT3_SLTU);
  wire inst_xori  = is_opi & (funct3 == FUNCT3_XOR);
  wire inst_ori   = is_opi & (funct3 == FUNCT3_OR);
  wire inst_andi  = is_opi & (funct3 == FUNCT3_AND);
  wire inst_slli  = is_opi & (funct3 == FUNCT3_SLL) & f7_base;
  wire inst_srli  = is_opi & (funct3 == FUNCT3_SR)  & f7_base;
  wire inst_srai  = is_opi & (funct3 == FUNCT3_SR)  & f7_alt;

  wire inst_beq   = is_br & (funct3 == FUNCT3_BEQ);
  wire inst_bne   = is_br & (funct3 == FUNCT3_BNE);
  wire inst_blt   = is_br & (funct3 == FUNCT3_BLT);
  wire inst_bge   = is_br & (funct3 == FUNCT3_BGE);
  wire inst_bltu  = is_br & (funct3 == FUNCT3_BLTU);
  wire inst_bgeu  = is_br & (funct3 == FUNCT3_BGEU);
  wire inst_jal   = (opcode == OPCODE_JAL);
  wire inst_jalr  = (opcode == OPCODE_JALR) & (funct3 == FUNCT3_JALR);
  wire inst_lui   = (opcode == OPCODE_LUI);
  wire inst_auipc = (opcode == OPCODE_AUIPC);

  wire inst_ecall  = is_sys & (funct3 == FUNCT3_PRIV) & (funct12 == FUNCT12_ECALL);
  wire inst_ebreak = is_sys & (funct3 == FUNCT3_PRIV) & (funct12 == FUNCT12_EBREAK);
  wire inst_mret   = is_sys & (funct3 == FUNCT3_PRIV) & (funct12 == FUNCT12_MRET);
  wire inst_csr    = is_sys & ((funct3 == FUNCT3_CSRRW) | (funct3 == FUNCT3_CSRRS));

  lsu_op_e lsu_op;

  always_comb begin
    case ({opcode, funct3})
      {OPCODE_LOAD, FUNCT3_LB}:  lsu_op = LSU_OP_LB;
      {OPCODE_LOAD, FUNCT3_LH}:  lsu_op = LSU_OP_LH;
      {OPCODE_LOAD, FUNCT3_LW}:  lsu_op = LSU_OP_LW;
      {OPCODE_LOAD, FUNCT3_LBU}: lsu_op = LSU_OP_LBU;
      {OPCODE_LOAD, FUNCT3_LHU}: lsu_op = LSU_OP_LHU;
      {OPCODE_STORE, FUNCT3_SB}: lsu_op = LSU_OP_SB;
      {OPCODE_STORE, FUNCT3_SH}: lsu_op = LSU_OP_SH;
      {OPCODE_STORE, FUNCT3_SW}: lsu_op = LSU_OP_SW;
      default:                   lsu_op = LSU_OP_NOP;
    endcase
  end

  wire inst_rr  = inst_add | inst_sub | inst_sll | inst_slt | inst_sltu |
                  inst_xor | inst_srl | inst_sra | inst_or  | inst_and;
  wire inst_ri  = inst_addi | inst_slti | inst_sltiu | inst_xori | inst_ori |
                  inst_andi | inst_slli | inst_srli  | inst_srai;
  wire inst_bxx = inst_beq | inst_bne | inst_blt | inst_bge | inst_bltu | inst_bgeu;
  wire inst_ld  = (lsu_op inside {LSU_OP_LB, LSU_OP_LH, LSU_OP_LW, LSU_OP_LBU, LSU_OP_LHU});
  wire inst_st  = (lsu_op inside {LSU_OP_SB, LSU_OP_SH, LSU_OP_SW});
  wire inst_sys = inst_ecall | inst_ebreak | inst_mret | inst_csr;
  wire known    = inst_rr | inst_ri | inst_bxx | inst_jal | inst_jalr | inst_lui |
                  inst_auipc | inst_ld | inst_st | inst_sys | inst_muldv;

  // Fetch address must be word aligned.
  wire pc_misaligned = (pc_i[1:0] != 2'b00);

  assign unsupported_o = ~known | inst_ld | inst_st | inst_sys | inst_muldv | pc_misaligned;

  // ##############################
  // Operation encoding
  // ##############################
  always_comb begin
    case (opcode)
      OPCODE_OP:     inst_class_o = INST_RR;
      OPCODE_OP_IMM: inst_class_o = INST_RI;
      OPCODE_LOAD:   inst_class_o = INST_LOAD;
      OPCODE_STORE:  inst_class_o = INST_STORE;
      OPCODE_BRANCH: inst_class_o = INST_BRANCH;
      OPCODE_JAL:    inst_class_o = INST_JAL;
      OPCODE_JALR:   inst_class_o = INST_JALR;
      OPCODE_LUI:    inst_class_o = INST_LUI;
      OPCODE_AUIPC:  inst_class_o = INST_AUIPC;
      OPCODE_SYSTEM: inst_class_o = INST_SYSTEM;
      default:       inst_class_o = INST_NOP;
    endcase
  end

  always_comb begin
    case (inst_class_o)
      INST_RI:                           imm_o = (inst_slli | inst_srli | inst_srai) ?
                                                 imm_sh : imm_i;
      INST_LOAD, INST_JALR, INST_SYSTEM: imm_o = imm_i;
      INST_STORE:                        imm_o = imm_s;
      INST_BRANCH:                       imm_o = imm_b;
      INST_JAL:                          imm_o = imm_j;
      INST_LUI, INST_AUIPC:              imm_o = imm_u;
      default:                           imm_o = '0;
    endcase
  end

  assign alu_op_o = (inst_add  | inst_addi)  ? ALU_OP_ADD  :
                    (inst_sub)               ? ALU_OP_SUB  :
                    (inst_xor  | inst_xori)  ? ALU_OP_XOR  :
                    (inst_or   | inst_ori)   ? ALU_OP_OR   :
                    (inst_and  | inst_andi)  ? ALU_OP_AND  :
                    (inst_sll  | inst_slli)  ? ALU_OP_SLL  :
                    (inst_srl  | inst_srli)  ? ALU_OP_SRL  :
                    (inst_sra  | inst_srai)  ? ALU_OP_SRA  :
                    (inst_slt  | inst_slti)  ? ALU_OP_SLT  :
                    (inst_sltu | inst_sltiu) ? ALU_OP_SLTU :
                    (inst_jal  | inst_jalr)  ? ALU_OP_JUMP : ALU_OP_NOP;

  assign bpu_op_o = inst_beq  ? BPU_OP_BEQ  :
                    inst_bne  ? BPU_OP_BNE  :
                    inst_blt  ? BPU_OP_BLT  :
                    inst_bge  ? BPU_OP_BGE  :
                    inst_bltu ? BPU_OP_BLTU :
                    inst_bgeu ? BPU_OP_BGEU :
                    inst_jal  ? BPU_OP_JAL  :
                    inst_jalr ? BPU_OP_JALR : BPU_OP_NOP;

  assign alu_src_imm_o = (inst_class_o == INST_RI);

  assign wena_o  = inst_rr | inst_ri | inst_jal | inst_jalr | inst_lui | inst_auipc |
                   inst_ld | inst_csr | inst_muldv;
  assign waddr_o = wena_o ? rd : ZERO_REG;

  // Unused read ports park on x0.
  assign raddr1_o = (inst_rr | inst_ri | inst_bxx | inst_jalr | inst_ld | inst_st |
                     inst_csr | inst_muldv) ? rs1 : ZERO_REG;
  assign raddr2_o = (inst_rr | inst_bxx | inst_st | inst_muldv) ? rs2 : ZERO_REG;

endmodule

//--- hdl/rv_regfile.sv
`timescale 1ns/10ps

module rv_regfile import rv_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_n_i,
  input  reg_addr_t raddr1_i,
  input  reg_addr_t raddr2_i,
  output word_t     rdata1_o,
  output word_t     rdata2_o,
  input  logic      we_i,
  input  reg_addr_t waddr_i,
  input  word_t     wdata_i
);

  word_t regs [1:NUM_REGS-1];   // x0 has no storage.

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int i = 1; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (we_i && (waddr_i != ZERO_REG)) begin
      regs[waddr_i] <= wdata_i;
    end
  end

  assign rdata1_o = (raddr1_i == ZERO_REG) ? '0 : regs[raddr1_i];
  assign rdata2_o = (raddr2_i == ZERO_REG) ? '0 : regs[raddr2_i];

endmodule

//--- hdl/rv_alu.sv
`timescale 1ns/10ps

module rv_alu import rv_pkg::*; (
  input  alu_op_e alu_op_i,
  input  logic    alu_src_imm_i,
  input  word_t   rs1_i,
  input  word_t   rs2_i,
  input  word_t   imm_i,
  output word_t   result_o
);

  word_t op_b;
  logic  [4:0] shamt;

  assign op_b  = alu_src_imm_i ? imm_i : rs2_i;
  assign shamt = op_b[4:0];

  always_comb begin
    case (alu_op_i)
      ALU_OP_ADD:  result_o = rs1_i + op_b;
      ALU_OP_SUB:  result_o = rs1_i - op_b;
      ALU_OP_XOR:  result_o = rs1_i ^ op_b;
      ALU_OP_OR:   result_o = rs1_i | op_b;
      ALU_OP_AND:  result_o = rs1_i & op_b;
      ALU_OP_SLL:  result_o = rs1_i << shamt;
      ALU_OP_SRL:  result_o = rs1_i >> shamt;
      ALU_OP_SRA:  result_o = word_t'($signed(rs1_i) >>> shamt);
      ALU_OP_SLT:  result_o = {31'b0, $signed(rs1_i) < $signed(op_b)};
      ALU_OP_SLTU: result_o = {31'b0, rs1_i < op_b};
      default:     result_o = '0;   // Link value comes from writeback.
    endcase
  end

endmodule

//--- hdl/rv_branch_unit.sv
`timescale 1ns/10ps

module rv_branch_unit import rv_pkg::*; (
  input  bpu_op_e bpu_op_i,
  input  addr_t   pc_i,
  input  word_t   rs1_i,
  input  word_t   rs2_i,
  input  word_t   imm_i,
  output logic    taken_o,
  output addr_t   target_o
);

  addr_t jalr_sum;

  always_comb begin
    case (bpu_op_i)
      BPU_OP_BEQ:  taken_o = (rs1_i == rs2_i);
      BPU_OP_BNE:  taken_o = (rs1_i != rs2_i);
      BPU_OP_BLT:  taken_o = ($signed(rs1_i) <  $signed(rs2_i));
      BPU_OP_BGE:  taken_o = ($signed(rs1_i) >= $signed(rs2_i));
      BPU_OP_BLTU: taken_o = (rs1_i <  rs2_i);
      BPU_OP_BGEU: taken_o = (rs1_i >= rs2_i);
      BPU_OP_JAL,
      BPU_OP_JALR: taken_o = 1'b1;
      default:     taken_o = 1'b0;
    endcase
  end

  assign jalr_sum = rs1_i + imm_i;
  assign target_o = (bpu_op_i == BPU_OP_JALR) ? {jalr_sum[31:1], 1'b0} : (pc_i + imm_i);

endmodule

//--- hdl/rv_writeback.sv
`timescale 1ns/10ps

module rv_writeback import rv_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_n_i,
  input  logic        inst_valid_i,
  input  inst_class_e inst_class_i,
  input  addr_t       pc_i,
  input  word_t       imm_i,
  input  word_t       alu_result_i,
  input  logic        taken_i,
  input  addr_t       target_i,
  input  logic        wena_i,
  input  reg_addr_t   waddr_i,
  input  logic        unsupported_i,
  output logic        rf_we_o,
  output reg_addr_t   rf_waddr_o,
  output word_t       rf_wdata_o,
  output logic        retire_valid_o,
  output logic        retire_we_o,
  output reg_addr_t   retire_rd_o,
  output word_t       retire_wdata_o,
  output addr_t       next_pc_o,
  output logic        illegal_o
);

  addr_t link_addr;
  addr_t next_pc;
  word_t wdata;

  assign link_addr = pc_i + INST_BYTES;

  always_comb begin
    case (inst_class_i)
      INST_JAL, INST_JALR: wdata = link_addr;
      INST_LUI:            wdata = imm_i;
      INST_AUIPC:          wdata = pc_i + imm_i;
      default:             wdata = alu_result_i;
    endcase
  end

  assign next_pc    = (taken_i && !unsupported_i) ? target_i : link_addr;
  assign rf_we_o    = inst_valid_i & wena_i & ~unsupported_i;
  assign rf_waddr_o = waddr_i;
  assign rf_wdata_o = wdata;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      retire_valid_o <= 1'b0;
      retire_we_o    <= 1'b0;
      illegal_o      <= 1'b0;
      retire_rd_o    <= ZERO_REG;
      retire_wdata_o <= '0;
      next_pc_o      <= '0;
    end else begin
      retire_valid_o <= inst_valid_i;
      retire_we_o    <= rf_we_o;
      illegal_o      <= inst_valid_i & unsupported_i;
      if (inst_valid_i) begin   // Record holds between instructions.
        retire_rd_o    <= waddr_i;
        retire_wdata_o <= wdata;
        next_pc_o      <= next_pc;
      end
    end
  end

endmodule

//--- hdl/rv_exec_core.sv
`timescale 1ns/10ps

module rv_exec_core import rv_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_n_i,
  input  logic      inst_valid_i,
  input  addr_t     pc_i,
  input  inst_t     inst_i,
  output logic      retire_valid_o,
  output logic      retire_we_o,
  output reg_addr_t retire_rd_o,
  output word_t     retire_wdata_o,
  output addr_t     next_pc_o,
  output logic      illegal_o
);

  inst_class_e inst_class;
  alu_op_e     alu_op;
  bpu_op_e     bpu_op;
  logic        alu_src_imm;
  logic        wena;
  logic        unsupported;
  logic        taken;
  logic        rf_we;
  reg_addr_t   waddr;
  reg_addr_t   raddr1;
  reg_addr_t   raddr2;
  reg_addr_t   rf_waddr;
  word_t       imm;
  word_t       rdata1;
  word_t       rdata2;
  word_t       alu_result;
  word_t       rf_wdata;
  addr_t       target;

  rv_decode i_rv_decode (
    .pc_i          (pc_i),
    .inst_i        (inst_i),
    .inst_class_o  (inst_class),
    .alu_op_o      (alu_op),
    .bpu_op_o      (bpu_op),
    .alu_src_imm_o (alu_src_imm),
    .wena_o        (wena),
    .waddr_o       (waddr),
    .imm_o         (imm),
    .raddr1_o      (raddr1),
    .raddr2_o      (raddr2),
    .unsupported_o (unsupported)
  );

  rv_regfile i_rv_regfile (
    .clk_i    (clk_i),
    .rst_n_i  (rst_n_i),
    .raddr1_i (raddr1),
    .raddr2_i (raddr2),
    .rdata1_o (rdata1),
    .rdata2_o (rdata2),
    .we_i     (rf_we),
    .waddr_i  (rf_waddr),
    .wdata_i  (rf_wdata)
  );

  rv_alu i_rv_alu (
    .alu_op_i      (alu_op),
    .alu_src_imm_i (alu_src_imm),
    .rs1_i         (rdata1),
    .rs2_i         (rdata2),
    .imm_i         (imm),
    .result_o      (alu_result)
  );

  rv_branch_unit i_rv_branch_unit (
    .bpu_op_i (bpu_op),
    .pc_i     (pc_i),
    .rs1_i    (rdata1),
    .rs2_i    (rdata2),
    .imm_i    (imm),
    .taken_o  (taken),
    .target_o (target)
  );

  rv_writeback i_rv_writeback (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .inst_valid_i   (inst_valid_i),
    .inst_class_i   (inst_class),
    .pc_i           (pc_i),
    .imm_i          (imm),
    .alu_result_i   (alu_result),
    .taken_i        (taken),
    .target_i       (target),
    .wena_i         (wena),
    .waddr_i        (waddr),
    .unsupported_i  (unsupported),
    .rf_we_o        (rf_we),
    .rf_waddr_o     (rf_waddr),
    .rf_wdata_o     (rf_wdata),
    .retire_valid_o (retire_valid_o),
    .retire_we_o    (retire_we_o),
    .retire_rd_o    (retire_rd_o),
    .retire_wdata_o (retire_wdata_o),
    .next_pc_o      (next_pc_o),
    .illegal_o      (illegal_o)
  );

endmodule

//--- tests/tb_rv_exec_core.sv
`timescale 1ns/10ps

module tb_rv_exec_core import rv_pkg::*; ();

  localparam int TIMEOUT   = 20;
  localparam int NUM_RANDOM = 2000;

  logic      clk;
  logic      rst_n;
  logic      inst_valid;
  addr_t     pc;
  inst_t     inst;
  logic      retire_valid;
  logic      retire_we;
  reg_addr_t retire_rd;
  word_t     retire_wdata;
  addr_t     next_pc;
  logic      illegal;

  word_t       mirror [NUM_REGS];
  logic [31:0] lcg_state;
  int          errors;
  int          checks;
  int          timeouts;
  logic        exp_we;
  logic        exp_illegal;
  reg_addr_t   exp_rd;
  word_t       exp_wdata;
  addr_t       exp_npc;

  rv_exec_core i_rv_exec_core (
    .clk_i          (clk),
    .rst_n_i        (rst_n),
    .inst_valid_i   (inst_valid),
    .pc_i           (pc),
    .inst_i         (inst),
    .retire_valid_o (retire_valid),
    .retire_we_o    (retire_we),
    .retire_rd_o    (retire_rd),
    .retire_wdata_o (retire_wdata),
    .next_pc_o      (next_pc),
    .illegal_o      (illegal)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // ##############################
  // Stimulus helpers
  // ##############################
  function automatic logic [31:0] lcg_next();
    logic [15:0] hi;
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    hi = lcg_state[31:16];   // Low LCG bits are weak.
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return {hi, lcg_state[31:16]};
  endfunction

  function automatic inst_t r_type(logic [6:0] f7, reg_addr_t rs2, reg_addr_t rs1,
                                   logic [2:0] f3, reg_addr_t rd, logic [6:0] op);
    return {f7, rs2, rs1, f3, rd, op};
  endfunction

  function automatic inst_t i_type(logic [11:0] imm, reg_addr_t rs1, logic [2:0] f3,
                                   reg_addr_t rd, logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic inst_t b_type(logic [12:0] imm, reg_addr_t rs2, reg_addr_t rs1,
                                   logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OPCODE_BRANCH};
  endfunction

  function automatic inst_t j_type(logic [20:0] imm, reg_addr_t rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPCODE_JAL};
  endfunction

  task automatic gen_inst(output inst_t in);
    logic [31:0] r;
    logic [31:0] f;
    reg_addr_t   rd;
    reg_addr_t   rs1;
    reg_addr_t   rs2;
    logic [2:0]  f3;
    int          pick;
    r = lcg_next();
    f = lcg_next();
    rd = f[4:0];
    rs1 = f[9:5];
    rs2 = f[14:10];
    f3 = f[17:15];
    pick = int'(r % 100);
    if (pick < 25) begin
      in = r_type(((f3 == 3'd0 || f3 == 3'd5) && f[18]) ? FUNCT7_ALT : FUNCT7_BASE,
                  rs2, rs1, f3, rd, OPCODE_OP);
    end else if (pick < 45) begin
      if (f3 == 3'd1 || f3 == 3'd5) begin   // Shift immediates.
        in = r_type((f3 == 3'd5 && f[18]) ? FUNCT7_ALT : FUNCT7_BASE,
                    rs2, rs1, f3, rd, OPCODE_OP_IMM);
      end else begin
        in = i_type(f[31:20], rs1, f3, rd, OPCODE_OP_IMM);
      end
    end else if (pick < 57) begin
      in = b_type({f[31:20], 1'b0}, rs2, rs1, (f3 == 3'd2 || f3 == 3'd3) ? f3 + 3'd4 : f3);
    end else if (pick < 62) begin
      in = j_type({f[31:12], 1'b0}, rd);
    end else if (pick < 67) begin
      in = i_type(f[31:20], rs1, FUNCT3_JALR, rd, OPCODE_JALR);
    end else if (pick < 72) begin
      in = {f[31:12], rd, OPCODE_LUI};
    end else if (pick < 77) begin
      in = {f[31:12], rd, OPCODE_AUIPC};
    end else if (pick < 87) begin
      case (f[19:18])
        2'd0:    in = i_type(f[31:20], rs1, FUNCT3_LW, rd, OPCODE_LOAD);
        2'd1:    in = r_type(f[31:25], rs2, rs1, FUNCT3_SW, rd, OPCODE_STORE);
        2'd2:    in = i_type(f[20] ? FUNCT12_EBREAK : FUNCT12_ECALL, 5'd0, FUNCT3_PRIV,
                             5'd0, OPCODE_SYSTEM);
        default: in = r_type(FUNCT7_MULDIV, rs2, rs1, f3, rd, OPCODE_OP);
      endcase
    end else begin
      in = f;   // Raw word.
    end
  endtask

  // ##############################
  // Reference model
  // ##############################
  task automatic predict(input inst_t in, input addr_t at);
    logic [6:0] opcode;
    logic [2:0] f3;
    logic [6:0] f7;
    word_t      rs1v;
    word_t      rs2v;
    word_t      opb;
    word_t      imm_i;
    word_t      imm_b;
    word_t      imm_u;
    word_t      imm_j;
    word_t      value;
    logic       alt;
    logic       legal;
    logic       writes;
    logic       taken;
    opcode = in[6:0];
    f3 = in[14:12];
    f7 = in[31:25];
    rs1v = mirror[in[19:15]];
    rs2v = mirror[in[24:20]];
    imm_i = {{20{in[31]}}, in[31:20]};
    imm_b = {{19{in[31]}}, in[31], in[7], in[30:25], in[11:8], 1'b0};
    imm_u = {in[31:12], 12'h000};
    imm_j = {{11{in[31]}}, in[31], in[19:12], in[20], in[30:21], 1'b0};
    legal = 1'b0;
    writes = 1'b1;
    taken = 1'b0;
    value = '0;
    exp_npc = at + 32'd4;
    case (opcode)
      OPCODE_OP, OPCODE_OP_IMM: begin
        opb = (opcode == OPCODE_OP) ? rs2v : imm_i;
        alt = f7[5] && (opcode == OPCODE_OP || f3 == 3'd5);
        legal = (opcode == OPCODE_OP) ?
                ((f7 == 7'h00) || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5))) :
                (!(f3 == 3'd1 && f7 != 7'h00) &&
                 !(f3 == 3'd5 && f7 != 7'h00 && f7 != 7'h20));
        case (f3)
          3'd0:    value = alt ? rs1v - opb : rs1v + opb;
          3'd1:    value = rs1v << opb[4:0];
          3'd2:    value = {31'd0, $signed(rs1v) < $signed(opb)};
          3'd3:    value = {31'd0, rs1v < opb};
          3'd4:    value = rs1v ^ opb;
          3'd5:    value = alt ? word_t'($signed(rs1v) >>> opb[4:0]) : rs1v >> opb[4:0];
          3'd6:    value = rs1v | opb;
          default: value = rs1v & opb;
        endcase
      end
      OPCODE_LUI: begin
        legal = 1'b1;
        value = imm_u;
      end
      OPCODE_AUIPC: begin
        legal = 1'b1;
        value = at + imm_u;
      end
      OPCODE_JAL: begin
        legal = 1'b1;
        value = at + 32'd4;
        exp_npc = at + imm_j;
      end
      OPCODE_JALR: begin
        legal = (f3 == 3'd0);
        value = at + 32'd4;
        if (legal) exp_npc = (rs1v + imm_i) & ~32'd1;
      end
      OPCODE_BRANCH: begin
        writes = 1'b0;
        legal = (f3 != 3'd2) && (f3 != 3'd3);
        case (f3)
          3'd0:    taken = (rs1v == rs2v);
          3'd1:    taken = (rs1v != rs2v);
          3'd4:    taken = ($signed(rs1v) < $signed(rs2v));
          3'd5:    taken = ($signed(rs1v) >= $signed(rs2v));
          3'd6:    taken = (rs1v < rs2v);
          default: taken = (rs1v >= rs2v);
        endcase
        if (legal && taken) exp_npc = at + imm_b;
      end
      default: legal = 1'b0;   // Memory, system and unknown.
    endcase
    exp_illegal = !legal;
    exp_we = legal && writes;
    exp_rd = in[11:7];
    exp_wdata = value;
    if (exp_we && exp_rd != 5'd0) mirror[exp_rd] = value;
  endtask

  // ##############################
  // Issue and checks
  // ##############################
  task automatic check_word(input word_t got, input word_t exp, input string what);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("FAILED at %0d ns: %s is %h, expected %h (inst %h, pc %h)",
               $time, what, got, exp, inst, pc);
    end
  endtask

  task automatic run_inst(input inst_t in, input addr_t at);
    int cycles;
    if (timeouts == 0) begin   // A hung DUT stops further issue.
      predict(in, at);
      inst = in;
      pc = at;
      inst_valid = 1'b1;
      @(negedge clk);
      inst_valid = 1'b0;
      cycles = 1;
      while (!retire_valid && cycles < TIMEOUT) begin
        @(negedge clk);
        cycles++;
      end
      if (!retire_valid) begin
        timeouts++;
        $display("No retire seen within %0d cycles of issuing %h", TIMEOUT, in);
      end else begin
        check_word(word_t'(cycles), 32'd1, "retire latency");
        check_word(word_t'(illegal), word_t'(exp_illegal), "illegal_o");
        check_word(word_t'(retire_we), word_t'(exp_we), "retire_we_o");
        check_word(next_pc, exp_npc, "next_pc_o");
        if (exp_we) begin
          check_word(word_t'(retire_rd), word_t'(exp_rd), "retire_rd_o");
          check_word(retire_wdata, exp_wdata, "retire_wdata_o");
        end
      end
    end
  endtask

  task automatic idle_cycles(input int n);
    if (timeouts == 0) begin
      for (int i = 0; i < n; i++) begin
        @(negedge clk);
        check_word(word_t'(retire_valid), 32'd0, "retire_valid_o while idle");
      end
    end
  endtask

  task automatic probe_regs(input addr_t base);
    for (int k = 0; k < NUM_REGS; k++) begin   // ADD x0, xk, x0.
      run_inst(r_type(FUNCT7_BASE, 5'd0, reg_addr_t'(k), FUNCT3_ADD, 5'd0, OPCODE_OP),
               base + addr_t'(k * 4));
    end
  endtask

  initial begin
    inst_t       rnd_inst;
    logic [31:0] r;
    rst_n = 1'b0;
    inst_valid = 1'b0;
    pc = '0;
    inst = '0;
    errors = 0;
    checks = 0;
    timeouts = 0;
    lcg_state = 32'h6dae;
    for (int i = 0; i < NUM_REGS; i++) begin
      mirror[i] = '0;
    end
    repeat (3) @(negedge clk);
    rst_n = 1'b1;

    check_word(word_t'(retire_valid), 32'd0, "retire_valid_o after reset");
    check_word(word_t'(retire_we), 32'd0, "retire_we_o after reset");
    check_word(word_t'(illegal), 32'd0, "illegal_o after reset");
    check_word(word_t'(retire_rd), 32'd0, "retire_rd_o after reset");
    check_word(retire_wdata, 32'd0, "retire_wdata_o after reset");
    check_word(next_pc, 32'd0, "next_pc_o after reset");
    idle_cycles(4);
    probe_regs(32'h0000_0100);

    // Dependent chain, issued back to back.
    run_inst(i_type(12'd5, 5'd0, FUNCT3_ADD, 5'd1, OPCODE_OP_IMM), 32'h200);
    run_inst(i_type(12'hffd, 5'd0, FUNCT3_ADD, 5'd2, OPCODE_OP_IMM), 32'h204);
    run_inst(r_type(FUNCT7_ALT, 5'd2, 5'd1, FUNCT3_ADD, 5'd3, OPCODE_OP), 32'h208);
    run_inst(r_type(FUNCT7_ALT, 5'd1, 5'd2, FUNCT3_SR, 5'd4, OPCODE_OP), 32'h20c);
    run_inst(r_type(FUNCT7_BASE, 5'd2, 5'd1, FUNCT3_SLTU, 5'd5, OPCODE_OP), 32'h210);
    run_inst(i_type(12'h07b, 5'd1, FUNCT3_ADD, 5'd0, OPCODE_OP_IMM), 32'h214);   // x0 stays 0.
    run_inst(r_type(FUNCT7_BASE, 5'd0, 5'd0, FUNCT3_ADD, 5'd6, OPCODE_OP), 32'h218);
    idle_cycles(2);
    run_inst(b_type(13'h0010, 5'd2, 5'd1, FUNCT3_BLT), 32'h21c);    // Not taken.
    run_inst(b_type(13'h1ff0, 5'd2, 5'd1, FUNCT3_BLTU), 32'h220);   // Taken backwards.
    run_inst(j_type(21'h000800, 5'd7), 32'h224);
    run_inst(i_type(12'h002, 5'd1, FUNCT3_JALR, 5'd8, OPCODE_JALR), 32'h228);   // Odd sum.
    run_inst({20'habcde, 5'd9, OPCODE_LUI}, 32'h22c);
    run_inst({20'h00001, 5'd10, OPCODE_AUIPC}, 32'h230);
    run_inst(i_type(12'h010, 5'd1, FUNCT3_LW, 5'd11, OPCODE_LOAD), 32'h234);
    run_inst(r_type(FUNCT7_MULDIV, 5'd2, 5'd1, FUNCT3_ADD, 5'd12, OPCODE_OP), 32'h238);
    run_inst(i_type(FUNCT12_ECALL, 5'd0, FUNCT3_PRIV, 5'd0, OPCODE_SYSTEM), 32'h23c);

    for (int n = 0; n < NUM_RANDOM; n++) begin
      gen_inst(rnd_inst);
      r = lcg_next();
      run_inst(rnd_inst, {r[31:2], 2'b00});
      if (r[1:0] == 2'b00) begin
        idle_cycles(int'(r[3:2]) + 1);
      end
    end
    probe_regs(32'h0000_8000);

    $display("Checks: %0d, errors: %0d, timeouts: %0d", checks, errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

//--- sources.f
common/rv_pkg.sv
decode/rv_decode.sv
hdl/rv_regfile.sv
hdl/rv_alu.sv
hdl/rv_branch_unit.sv
hdl/rv_writeback.sv
hdl/rv_exec_core.sv
tests/tb_rv_exec_core.sv

//--- run.sh
#!/bin/sh
# Build with Verilator and run the RV32I execute slice testbench.
cd "$(dirname "$0")" &&
verilator --binary --timing -Wno-fatal --top-module tb_rv_exec_core \
  -f sources.f -o tb_sim &&
./obj_dir/tb_sim | tee /dev/stderr | grep "TESTBENCH PASSED" > /dev/null &&
echo "Simulation passed" ||
{ echo "Simulation failed"; exit 1; }
